// ==== Makefile ====
# Verilator build and run for the mailbox boot block
# any of these can be overridden on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_mbox_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS := $(wildcard hw/*.svh testbench/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported a failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
+incdir+hw
+incdir+testbench
hw/mbox_pkg.sv
hw/mbox_wb_if.sv
hw/mbox_fuse_regs.sv
hw/mbox_boot_fsm.sv
hw/mbox_top.sv
testbench/tb_mbox_top.sv

// ==== hw/mbox_boot_fsm.sv ====
// single clock, sync active-high reset, pwrgood is sampled only in idle and BOOT_DONE holds until reset
`timescale 1ns/1ps

module mbox_boot_fsm (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      pwrgood,
    input  logic                      fuse_done,
    output mbox_pkg::boot_fsm_state_e boot_state,
    output logic                      fuse_wr_en,
    output logic                      uc_rst
);

    import mbox_pkg::*;

    // present and next state
    boot_fsm_state_e boot_fsm_ps;
    boot_fsm_state_e boot_fsm_ns;
    // arcs between states
    logic            arc_idle_fuse;
    logic            arc_fuse_done;
    // microcontroller reset release chain
    logic            release_en;
    logic            uc_rst_q1;

    // leave idle once the SoC reports stable power
    // reset is synchronous, so it is already handled by the state register
    always_comb arc_idle_fuse = pwrgood;

    // fuse loading is finished when software sets the done flag
    always_comb arc_fuse_done = fuse_done;

    always_comb begin
        case (boot_fsm_ps)
            BOOT_IDLE: begin
                if (arc_idle_fuse) begin
                    boot_fsm_ns = BOOT_FUSE;
                end
                else begin
                    boot_fsm_ns = BOOT_IDLE;
                end
            end
            BOOT_FUSE: begin
                if (arc_fuse_done) begin
                    boot_fsm_ns = BOOT_DONE;
                end
                else begin
                    boot_fsm_ns = BOOT_FUSE;
                end
            end
            BOOT_DONE: begin
                // sticky until the next reset
                boot_fsm_ns = BOOT_DONE;
            end
            default: begin
                // a corrupted code parks here until reset
                boot_fsm_ns = BOOT_X;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            boot_fsm_ps <= BOOT_IDLE;
        end
        else begin
            boot_fsm_ps <= boot_fsm_ns;
        end
    end

    always_comb boot_state = boot_fsm_ps;

    // the register block accepts fuse writes only in this state
    always_comb fuse_wr_en = (boot_fsm_ps == BOOT_FUSE);

    // release starts only once the machine has reached BOOT_DONE
    always_comb release_en = (boot_fsm_ps == BOOT_DONE);

    // two flops between the state and the pin
    // uc_rst drops two edges after BOOT_DONE is entered and stays low after that
    always_ff @(posedge clk) begin
        if (reset) begin
            uc_rst_q1 <= 1'b1;
            uc_rst    <= 1'b1;
        end
        else begin
            if (release_en) begin
                uc_rst_q1 <= 1'b0;
            end
            uc_rst <= uc_rst_q1;
        end
    end

endmodule

// ==== hw/mbox_defs.svh ====
// address map and widths are fixed for an 8-word fuse array on a 4-bit word-addressed bus
`ifndef MBOX_DEFS_SVH
`define MBOX_DEFS_SVH

// number of 32-bit fuse words held by the register block
`define MBOX_FUSE_COUNT 8

// wishbone data width and the byte select width that follows from it
`define MBOX_DATA_W 32
`define MBOX_SEL_W (`MBOX_DATA_W / 8)

// wishbone word address width
`define MBOX_ADDR_W 4

// width of the microcontroller fuse index
`define MBOX_FUSE_IDX_W 3

// word addresses above the fuse array
// addresses 0 to 7 hold the fuse words and anything not listed reads zero
`define MBOX_ADDR_FUSE_DONE 4'd8
`define MBOX_ADDR_STATUS 4'd9

`endif

// ==== hw/mbox_fuse_regs.sv ====
// fuse writes are honoured only while fuse_wr_en is high, no ECC or parity
`timescale 1ns/1ps

`include "mbox_defs.svh"

module mbox_fuse_regs (
    input  logic                        clk,
    input  logic                        reset,
    mbox_wb_if.slave                    wb,
    input  logic                        fuse_wr_en,
    input  mbox_pkg::boot_fsm_state_e   boot_state,
    output logic                        fuse_done,
    input  logic [`MBOX_FUSE_IDX_W-1:0] uc_fuse_index,
    output logic [`MBOX_DATA_W-1:0]     uc_fuse_data
);

    import mbox_pkg::*;

    // fuse word storage
    logic [`MBOX_DATA_W-1:0]     fuse_q [`MBOX_FUSE_COUNT];
    // register kind and fuse word picked by the current address
    mbox_reg_e                   reg_kind;
    logic [`MBOX_FUSE_IDX_W-1:0] fuse_idx;
    // a request is accepted on the edge where it is pending and not yet acked
    logic                        access;
    logic                        wr_access;
    // the write really lands only while the boot machine allows it
    logic                        wr_allowed;
    // addressed fuse word with the selected bytes replaced
    logic [`MBOX_DATA_W-1:0]     fuse_merged;

    // map a word address onto a register kind
    function automatic mbox_reg_e decode_reg(input logic [`MBOX_ADDR_W-1:0] adr);
        mbox_reg_e kind;
        if (int'(adr) < `MBOX_FUSE_COUNT) begin
            kind = REG_FUSE;
        end
        else if (adr == `MBOX_ADDR_FUSE_DONE) begin
            kind = REG_FUSE_DONE;
        end
        else if (adr == `MBOX_ADDR_STATUS) begin
            kind = REG_STATUS;
        end
        else begin
            kind = REG_NONE;
        end
        return kind;
    endfunction

    always_comb reg_kind = decode_reg(wb.adr);

    // the fuse array fills the bottom of the map, so the low address bits index it
    always_comb fuse_idx = wb.adr[`MBOX_FUSE_IDX_W-1:0];

    // ack low in the condition keeps a held request from being taken twice
    always_comb access = wb.cyc && wb.stb && !wb.ack;

    always_comb wr_access = access && wb.we;

    // fuse_wr_en is high only in BOOT_FUSE, so the fuses lock once the machine moves on
    always_comb wr_allowed = wr_access && fuse_wr_en;

    // ack is raised for exactly one cycle per request
    // the master drops or changes its request once it sees ack
    always_ff @(posedge clk) begin
        if (reset) begin
            wb.ack <= 1'b0;
        end
        else begin
            wb.ack <= access;
        end
    end

    // byte merge under sel
    // lanes that are not selected keep the stored value
    always_comb begin
        fuse_merged = fuse_q[fuse_idx];
        for (int b = 0; b < `MBOX_SEL_W; b++) begin
            if (wb.sel[b]) begin
                fuse_merged[8*b +: 8] = wb.dat_w[8*b +: 8];
            end
        end
    end

    // fuse words take the merged value on the accept edge, which is also the ack edge
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MBOX_FUSE_COUNT; i++) begin
                fuse_q[i] <= '0;
            end
        end
        else if (wr_allowed && (reg_kind == REG_FUSE)) begin
            fuse_q[fuse_idx] <= fuse_merged;
        end
    end

    // the done flag is write-once
    // only a one in bit 0 with its byte lane enabled sets it, and only reset clears it
    always_ff @(posedge clk) begin
        if (reset) begin
            fuse_done <= 1'b0;
        end
        else if (wr_allowed && (reg_kind == REG_FUSE_DONE) && wb.sel[0] && wb.dat_w[0]) begin
            fuse_done <= 1'b1;
        end
    end

    // read data follows the held address, so it is stable for the whole ack cycle
    always_comb begin
        case (reg_kind)
            REG_FUSE: begin
                wb.dat_r = fuse_q[fuse_idx];
            end
            REG_FUSE_DONE: begin
                wb.dat_r = `MBOX_DATA_W'(fuse_done);
            end
            REG_STATUS: begin
                // boot state code sits in the low two bits
                wb.dat_r = `MBOX_DATA_W'(boot_state);
            end
            default: begin
                wb.dat_r = '0;
            end
        endcase
    end

    // microcontroller side read port
    // purely combinational, the microcontroller samples it on its own schedule
    always_comb uc_fuse_data = fuse_q[uc_fuse_index];

endmodule

// ==== hw/mbox_pkg.sv ====
// types shared by the boot machine and the register block, the enum widths are fixed at 2 bits
package mbox_pkg;

    // boot sequence states
    // codes are visible to software through the status register, so they must not move
    typedef enum logic [1:0] {
        BOOT_IDLE = 2'd0,
        // fuse words may be written by the SoC only here
        BOOT_FUSE = 2'd1,
        // fuses are locked and the microcontroller is on its way out of reset
        BOOT_DONE = 2'd2,
        // reached only from a corrupted state code
        BOOT_X    = 2'd3
    } boot_fsm_state_e;

    // kind of register selected by a wishbone word address
    typedef enum logic [1:0] {
        // one of the fuse words, the low address bits pick which
        REG_FUSE      = 2'd0,
        // write-once fuse-done flag in bit 0
        REG_FUSE_DONE = 2'd1,
        // boot state read-back in bits 1:0
        REG_STATUS    = 2'd2,
        // unmapped, reads zero and drops writes
        REG_NONE      = 2'd3
    } mbox_reg_e;

endpackage

// ==== hw/mbox_top.sv ====
// one clock and one sync active-high reset, wishbone classic single cycles, no added latency
`timescale 1ns/1ps

`include "mbox_defs.svh"

module mbox_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        pwrgood,
    // wishbone classic slave port from the SoC
    input  logic [`MBOX_ADDR_W-1:0]     wb_adr,
    input  logic [`MBOX_DATA_W-1:0]     wb_dat_w,
    input  logic [`MBOX_SEL_W-1:0]      wb_sel,
    input  logic                        wb_we,
    input  logic                        wb_stb,
    input  logic                        wb_cyc,
    output logic [`MBOX_DATA_W-1:0]     wb_dat_r,
    output logic                        wb_ack,
    // microcontroller reset and fuse read port
    output logic                        uc_rst,
    input  logic [`MBOX_FUSE_IDX_W-1:0] uc_fuse_index,
    output logic [`MBOX_DATA_W-1:0]     uc_fuse_data
);

    import mbox_pkg::*;

    // status from the boot machine, fuse write enable to the registers, done flag back
    boot_fsm_state_e boot_state;
    logic            fuse_wr_en;
    logic            fuse_done;

    // internal wishbone bundle, the top plays the master side
    mbox_wb_if wb_bus ();

    // the SoC request passes straight through to the bundle
    assign wb_bus.adr   = wb_adr;
    assign wb_bus.dat_w = wb_dat_w;
    assign wb_bus.sel   = wb_sel;
    assign wb_bus.we    = wb_we;
    assign wb_bus.stb   = wb_stb;
    assign wb_bus.cyc   = wb_cyc;

    // response goes back out unregistered
    assign wb_dat_r = wb_bus.dat_r;
    assign wb_ack   = wb_bus.ack;

    // fuse words, done flag and status read-back
    mbox_fuse_regs u_fuse_regs (
        .clk           (clk),
        .reset         (reset),
        .wb            (wb_bus.slave),
        .fuse_wr_en    (fuse_wr_en),
        .boot_state    (boot_state),
        .fuse_done     (fuse_done),
        .uc_fuse_index (uc_fuse_index),
        .uc_fuse_data  (uc_fuse_data)
    );

    // boot sequencing and microcontroller reset release
    mbox_boot_fsm u_boot_fsm (
        .clk        (clk),
        .reset      (reset),
        .pwrgood    (pwrgood),
        .fuse_done  (fuse_done),
        .boot_state (boot_state),
        .fuse_wr_en (fuse_wr_en),
        .uc_rst     (uc_rst)
    );

endmodule

// ==== hw/mbox_wb_if.sv ====
// wishbone classic single cycles only, no bursts, retry or error, and ack is the only back-pressure
`timescale 1ns/1ps

`include "mbox_defs.svh"

interface mbox_wb_if;

    // word address, one word per 32-bit register
    logic [`MBOX_ADDR_W-1:0] adr;
    // write data from the master and read data from the slave
    logic [`MBOX_DATA_W-1:0] dat_w;
    logic [`MBOX_DATA_W-1:0] dat_r;
    // byte lane enables for writes
    logic [`MBOX_SEL_W-1:0]  sel;
    logic                    we;
    logic                    stb;
    logic                    cyc;
    // single-cycle registered acknowledge
    logic                    ack;

    // the master holds its request steady until it sees ack
    modport master (
        output adr, dat_w, sel, we, stb, cyc,
        input  dat_r, ack
    );

    // the slave answers every request within one cycle
    modport slave (
        input  adr, dat_w, sel, we, stb, cyc,
        output dat_r, ack
    );

endinterface

// ==== testbench/tb_mbox_tasks.svh ====
// expects clk, the wb_* drivers and abort_run in the including module, call every task at a falling edge
`ifndef TB_MBOX_TASKS_SVH
`define TB_MBOX_TASKS_SVH

// result counters, errors also come from the concurrent assertions
int    error_count = 0;
int    check_count = 0;
int    test_count = 0;
int    failed_tests = 0;
int    errors_at_start = 0;
string test_name;

// immediate assertion on one value
task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
        error_count++;
        $display("Mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
endtask

// one classic cycle, the request is held until ack is seen at a falling edge
task automatic bus_cycle(input logic we, input logic [`MBOX_ADDR_W-1:0] adr,
                         input logic [`MBOX_DATA_W-1:0] dat, input logic [`MBOX_SEL_W-1:0] sel,
                         output logic [`MBOX_DATA_W-1:0] rdata);
    int   cycles;
    logic seen;
    cycles = 0;
    seen = 1'b0;
    rdata = '0;
    wb_adr = adr;
    wb_dat_w = dat;
    wb_sel = sel;
    wb_we = we;
    wb_stb = 1'b1;
    wb_cyc = 1'b1;
    while (!seen) begin
        @(negedge clk);
        cycles++;
        if (wb_ack === 1'b1) begin
            // read data is valid for the whole ack cycle
            seen = 1'b1;
            rdata = wb_dat_r;
        end
        else if (cycles >= ACK_TIMEOUT) begin
            abort_run($sformatf("no wb_ack for the access to address %0d", adr));
        end
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
endtask

task automatic write_word(input logic [`MBOX_ADDR_W-1:0] adr, input logic [`MBOX_DATA_W-1:0] dat,
                          input logic [`MBOX_SEL_W-1:0] sel);
    logic [`MBOX_DATA_W-1:0] unused_data;
    bus_cycle(1'b1, adr, dat, sel, unused_data);
endtask

task automatic expect_read(input logic [`MBOX_ADDR_W-1:0] adr, input logic [`MBOX_DATA_W-1:0] exp);
    logic [`MBOX_DATA_W-1:0] rdata;
    bus_cycle(1'b0, adr, '0, '0, rdata);
    check_value($sformatf("wb_dat_r at address %0d", adr), rdata, exp);
endtask

task automatic start_test(input string name);
    test_name = name;
    errors_at_start = error_count;
endtask

// one line per finished test
task automatic finish_test();
    int errs;
    errs = error_count - errors_at_start;
    test_count++;
    if (errs == 0) begin
        $display("test %0d %s: ok", test_count, test_name);
    end
    else begin
        failed_tests++;
        $display("test %0d %s: FAIL with %0d errors", test_count, test_name, errs);
    end
endtask

`endif

// ==== testbench/tb_mbox_top.sv ====
// 40 ns clock, inputs change on the falling edge, fixed LFSR seed so every run is the same
`timescale 1ns/1ps

`include "mbox_defs.svh"

module tb_mbox_top;

    // cycles allowed for an ack and for the reset release
    localparam int ACK_TIMEOUT = 16;
    localparam int RELEASE_TIMEOUT = 16;
    localparam int RANDOM_WRITES = 24;

    logic                        clk;
    logic                        reset;
    logic                        pwrgood;
    logic [`MBOX_ADDR_W-1:0]     wb_adr;
    logic [`MBOX_DATA_W-1:0]     wb_dat_w;
    logic [`MBOX_SEL_W-1:0]      wb_sel;
    logic                        wb_we;
    logic                        wb_stb;
    logic                        wb_cyc;
    logic [`MBOX_DATA_W-1:0]     wb_dat_r;
    logic                        wb_ack;
    logic                        uc_rst;
    logic [`MBOX_FUSE_IDX_W-1:0] uc_fuse_index;
    logic [`MBOX_DATA_W-1:0]     uc_fuse_data;

    // expected fuse contents, built from the byte-merge rule
    logic [`MBOX_DATA_W-1:0]     fuse_model [`MBOX_FUSE_COUNT];
    logic [31:0]                 lfsr_state = 32'hd208fe3a;

    mbox_top u_mbox_top (
        .clk           (clk),
        .reset         (reset),
        .pwrgood       (pwrgood),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_sel        (wb_sel),
        .wb_we         (wb_we),
        .wb_stb        (wb_stb),
        .wb_cyc        (wb_cyc),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .uc_rst        (uc_rst),
        .uc_fuse_index (uc_fuse_index),
        .uc_fuse_data  (uc_fuse_data)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $finish;
    endtask

    `include "tb_mbox_tasks.svh"

    // right-shifting Galois LFSR, taps for x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'ha300_0000) : (state >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int n = 0; n < count; n++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    // bytes with their sel bit set come from the new data
    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] sel);
        logic [31:0] result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                result[8*b +: 8] = data[8*b +: 8];
            end
        end
        return result;
    endfunction

    // ack is a single-cycle pulse
    a_ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
    else begin
        error_count++;
        $display("Mismatch at %0t: wb_ack got 1 expected 0 after an ack cycle", $time);
    end

    // reset clears ack and holds the microcontroller in reset
    a_reset_state: assert property (@(posedge clk) reset |=> (!wb_ack && uc_rst))
    else begin
        error_count++;
        $display("Mismatch at %0t: wb_ack/uc_rst got %b/%b expected 0/1", $time, wb_ack, uc_rst);
    end

    // once released, uc_rst stays low until reset
    a_release_sticky: assert property (@(posedge clk) disable iff (reset) !uc_rst |=> !uc_rst)
    else begin
        error_count++;
        $display("Mismatch at %0t: uc_rst got 1 expected 0 after release", $time);
    end

    // compare all fuse words over wishbone and on the index port
    task automatic compare_all_fuses();
        for (int i = 0; i < `MBOX_FUSE_COUNT; i++) begin
            expect_read(4'(i), fuse_model[i]);
        end
        for (int i = 0; i < `MBOX_FUSE_COUNT; i++) begin
            uc_fuse_index = 3'(i);
            @(negedge clk);
            check_value($sformatf("uc_fuse_data at index %0d", i), uc_fuse_data, fuse_model[i]);
        end
    endtask

    // full writes to every word, the model is left alone when writes are locked
    task automatic write_all_fuses(input logic track);
        logic [31:0] data;
        for (int i = 0; i < `MBOX_FUSE_COUNT; i++) begin
            data = rand_bits(32);
            write_word(4'(i), data, 4'hf);
            if (track) begin
                fuse_model[i] = data;
            end
        end
    endtask

    task automatic random_partial_writes();
        logic [31:0] pick;
        logic [2:0]  idx;
        logic [3:0]  sel;
        logic [31:0] data;
        for (int n = 0; n < RANDOM_WRITES; n++) begin
            pick = rand_bits(3);
            idx = pick[2:0];
            pick = rand_bits(4);
            sel = pick[3:0];
            data = rand_bits(32);
            write_word({1'b0, idx}, data, sel);
            fuse_model[idx] = merge_bytes(fuse_model[idx], data, sel);
        end
    endtask

    initial begin
        int edges;
        clk = 1'b0;
        reset = 1'b1;
        pwrgood = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = '0;
        wb_we = 1'b0;
        wb_stb = 1'b0;
        wb_cyc = 1'b0;
        uc_fuse_index = '0;
        for (int i = 0; i < `MBOX_FUSE_COUNT; i++) begin
            fuse_model[i] = '0;
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;

        start_test("after reset");
        check_value("uc_rst", 32'(uc_rst), 32'd1);
        check_value("wb_ack", 32'(wb_ack), 32'd0);
        expect_read(`MBOX_ADDR_STATUS, 32'd0);
        finish_test();

        // the machine is still idle, so every write is acked and dropped
        start_test("writes with pwrgood low");
        write_all_fuses(1'b0);
        write_word(`MBOX_ADDR_FUSE_DONE, 32'h1, 4'hf);
        compare_all_fuses();
        expect_read(`MBOX_ADDR_FUSE_DONE, 32'd0);
        expect_read(`MBOX_ADDR_STATUS, 32'd0);
        check_value("uc_rst", 32'(uc_rst), 32'd1);
        finish_test();

        start_test("fuse loading");
        pwrgood = 1'b1;
        @(negedge clk);
        expect_read(`MBOX_ADDR_STATUS, 32'd1);
        write_all_fuses(1'b1);
        random_partial_writes();
        compare_all_fuses();
        for (int a = 10; a < 16; a++) begin
            expect_read(4'(a), 32'd0);
        end
        finish_test();

        // release lands on the third rising edge after the ack edge
        start_test("fuse done and release");
        write_word(`MBOX_ADDR_FUSE_DONE, 32'h1, 4'h1);
        edges = 0;
        while (uc_rst !== 1'b0) begin
            if (edges >= RELEASE_TIMEOUT) begin
                abort_run("uc_rst was not released after the fuse-done write");
            end
            @(negedge clk);
            edges++;
        end
        check_value("uc_rst release edge count", 32'(edges), 32'd3);
        expect_read(`MBOX_ADDR_STATUS, 32'd2);
        expect_read(`MBOX_ADDR_FUSE_DONE, 32'd1);
        finish_test();

        start_test("locked after done");
        pwrgood = 1'b0;
        write_all_fuses(1'b0);
        write_word(`MBOX_ADDR_FUSE_DONE, 32'h0, 4'hf);
        compare_all_fuses();
        expect_read(`MBOX_ADDR_FUSE_DONE, 32'd1);
        expect_read(`MBOX_ADDR_STATUS, 32'd2);
        check_value("uc_rst", 32'(uc_rst), 32'd0);
        finish_test();

        start_test("reset in done");
        reset = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        check_value("uc_rst", 32'(uc_rst), 32'd1);
        for (int i = 0; i < `MBOX_FUSE_COUNT; i++) begin
            fuse_model[i] = '0;
        end
        compare_all_fuses();
        expect_read(`MBOX_ADDR_STATUS, 32'd0);
        expect_read(`MBOX_ADDR_FUSE_DONE, 32'd0);
        finish_test();

        $display("tests: %0d run, %0d with errors, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0 && failed_tests == 0) begin
            $display("Test passed");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
